/* verilog/overlayPkg.sv */
`default_nettype none

package overlayPkg;

	// one word on the panel bus, also used for colours
	typedef logic [15:0] pixelData;
	// unsigned screen coordinate
	typedef logic [10:0] coord;
	// signed displacement applied on each step tick
	typedef logic signed [11:0] velocity;
	// word counter within one frame, setup words included
	typedef logic [16:0] frameIndex;

	// frame writer phases
	typedef enum logic {
		setupState,
		pixelState
	} writerState;

	// panel size in pixels
	localparam int screenWidth = 240;
	localparam int screenHeight = 320;

	// both boxes are square
	localparam int spriteSize = 20;
	// position after reset or an underflow
	localparam int spawnPos = 10;

	// panel command words
	localparam pixelData cmdColumn = 16'h002a;
	localparam pixelData cmdPage = 16'h002b;
	localparam pixelData cmdWrite = 16'h002c;
	// cursor setup words sent before the pixels
	localparam int setupWords = 7;

	// pixel colours
	localparam pixelData colourBoth = 16'h0000;
	localparam pixelData colourCharacter = 16'hf0ff;
	localparam pixelData colourCoin = 16'h00aa;
	localparam pixelData colourBackground = 16'hffff;

endpackage

`default_nettype wire

/* verilog/busOwner.sv */
`timescale 1ns/1ps
`default_nettype none

module busOwner (
	input  logic clk,
	input  logic rst,
	// CPU bus
	input  overlayPkg::pixelData cpuData,
	input  logic cpuWrN,
	input  logic cpuRdN,
	input  logic cpuCsN,
	input  logic cpuResetN,
	input  logic cpuRs,
	input  logic gameEnable,
	// engine bus
	input  overlayPkg::pixelData engData,
	input  logic engWrN,
	input  logic engCsN,
	input  logic engRs,
	output logic engineOwns,
	// panel bus
	output overlayPkg::pixelData lcdData,
	output logic lcdWrN,
	output logic lcdRdN,
	output logic lcdCsN,
	output logic lcdResetN,
	output logic lcdRs
);

	import overlayPkg::*;

	// memory write command seen on the CPU bus, RS and CS_n low
	logic cmdSeen;

	assign cmdSeen = (cpuData == cmdWrite) && !cpuRs && !cpuCsN;

	// claim or release follows gameEnable on the command cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			engineOwns <= 1'b0;
		else if (cmdSeen)
			engineOwns <= gameEnable;
	end

	// panel source select, no register in this path
	assign lcdData = engineOwns ? engData : cpuData;
	assign lcdWrN = engineOwns ? engWrN : cpuWrN;
	assign lcdCsN = engineOwns ? engCsN : cpuCsN;
	assign lcdRs = engineOwns ? engRs : cpuRs;
	// the engine only writes, so read stays inactive while it drives
	assign lcdRdN = engineOwns ? 1'b1 : cpuRdN;
	// panel reset always belongs to the CPU
	assign lcdResetN = cpuResetN;

endmodule

`default_nettype wire

/* verilog/frameWriter.sv */
`timescale 1ns/1ps
`default_nettype none

module frameWriter (
	input  logic clk,
	input  logic rst,
	input  logic engineOwns,
	input  overlayPkg::pixelData pixelColour,
	output overlayPkg::pixelData engData,
	output logic engWrN,
	output logic engCsN,
	output logic engRs,
	output overlayPkg::coord pixelX,
	output overlayPkg::coord pixelY,
	output logic pixelActive
);

	import overlayPkg::*;

	writerState state;
	frameIndex wordIndex;
	// second cycle of a word, strobes released
	logic phase;
	logic strobeN;

	// strobe low in the first cycle of every word
	assign strobeN = !(engineOwns && !phase);
	assign engWrN = strobeN;
	assign engCsN = strobeN;

	assign pixelActive = (state == pixelState);

	always_ff @(posedge clk)
	begin
		if (rst || !engineOwns)
		begin
			// idle at the frame start until the engine gets the bus
			state <= setupState;
			wordIndex <= '0;
			phase <= 1'b0;
			pixelX <= '0;
			pixelY <= '0;
		end
		else if (!phase)
			phase <= 1'b1;
		else
		begin
			phase <= 1'b0;
			if (wordIndex == frameIndex'(setupWords + screenWidth * screenHeight - 1))
			begin
				// last pixel done, start over with cursor setup
				state <= setupState;
				wordIndex <= '0;
				pixelX <= '0;
				pixelY <= '0;
			end
			else
			begin
				wordIndex <= wordIndex + 1'b1;
				if (state == setupState)
				begin
					if (wordIndex == frameIndex'(setupWords - 1))
						state <= pixelState;
				end
				else if (pixelX == coord'(screenWidth - 1))
				begin
					// next row
					pixelX <= '0;
					pixelY <= pixelY + 1'b1;
				end
				else
					pixelX <= pixelX + 1'b1;
			end
		end
	end

	// word on the bus for the current index
	always_comb
	begin
		engData = pixelColour;
		engRs = 1'b1;
		if (state == setupState)
		begin
			case (wordIndex[2:0])
				3'd0:
				begin
					engData = cmdColumn;
					engRs = 1'b0;
				end
				3'd3:
				begin
					engData = cmdPage;
					engRs = 1'b0;
				end
				3'd6:
				begin
					engData = cmdWrite;
					engRs = 1'b0;
				end
				// column and page start words are all zero
				default:
					engData = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/gameObjects.sv */
`timescale 1ns/1ps
`default_nettype none

module gameObjects #(
	parameter int unsigned stepPeriod = 1000000
) (
	input  logic clk,
	input  logic rst,
	input  logic engineOwns,
	input  overlayPkg::velocity characterVelX,
	input  overlayPkg::velocity characterVelY,
	input  overlayPkg::coord coinStartX,
	input  overlayPkg::coord coinStartY,
	input  overlayPkg::velocity coinVelX,
	input  overlayPkg::velocity coinVelY,
	output overlayPkg::coord characterX,
	output overlayPkg::coord characterY,
	output overlayPkg::coord coinX,
	output overlayPkg::coord coinY
);

	import overlayPkg::*;

	logic [31:0] stepCount;
	logic tick;

	// far limits, box kept fully on screen
	localparam coord limitX = coord'(screenWidth - spriteSize);
	localparam coord limitY = coord'(screenHeight - spriteSize);

	// position plus velocity, wide enough to see an underflow
	function automatic logic signed [12:0] addVel(input coord pos, input velocity vel);
		return $signed({2'b00, pos}) + $signed({vel[11], vel});
	endfunction

	// character axis, underflow respawns and the far edge clamps
	function automatic coord characterNext(input coord pos, input velocity vel,
		input coord limit, input logic step);
		logic signed [12:0] sum;
		sum = addVel(pos, vel);
		if (sum < 0)
			return coord'(spawnPos);
		if (sum >= $signed({2'b00, limit}))
			return limit;
		if (step)
			return sum[10:0];
		return pos;
	endfunction

	// coin axis, reloads its start while the CPU drives and wraps at the far edge
	function automatic coord coinNext(input coord pos, input velocity vel, input coord start,
		input coord limit, input logic step, input logic owns);
		logic signed [12:0] sum;
		sum = addVel(pos, vel);
		if (sum < 0)
			return coord'(spawnPos);
		if (!owns)
			return start;
		if (sum >= $signed({2'b00, limit}))
			return coord'(spriteSize + 1);
		if (step)
			return sum[10:0];
		return pos;
	endfunction

	// free running step tick
	assign tick = (stepCount == stepPeriod - 1);

	always_ff @(posedge clk)
	begin
		if (rst || tick)
			stepCount <= '0;
		else
			stepCount <= stepCount + 1'b1;
	end

	// edge rules apply every cycle, movement only on the tick
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			characterX <= coord'(spawnPos);
			characterY <= coord'(spawnPos);
			coinX <= coord'(spawnPos);
			coinY <= coord'(spawnPos);
		end
		else
		begin
			characterX <= characterNext(characterX, characterVelX, limitX, tick);
			characterY <= characterNext(characterY, characterVelY, limitY, tick);
			coinX <= coinNext(coinX, coinVelX, coinStartX, limitX, tick, engineOwns);
			coinY <= coinNext(coinY, coinVelY, coinStartY, limitY, tick, engineOwns);
		end
	end

endmodule

`default_nettype wire

/* verilog/pixelShader.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelShader (
	input  logic clk,
	input  logic rst,
	input  logic engineOwns,
	input  overlayPkg::coord pixelX,
	input  overlayPkg::coord pixelY,
	input  logic pixelActive,
	input  overlayPkg::coord characterX,
	input  overlayPkg::coord characterY,
	input  overlayPkg::coord coinX,
	input  overlayPkg::coord coinY,
	output overlayPkg::pixelData pixelColour,
	output logic finish
);

	import overlayPkg::*;

	logic inCharacter;
	logic inCoin;
	logic collision;

	// half-open box test, one extra bit so a box near the top of the range cannot wrap
	function automatic logic boxHit(input coord px, input coord py, input coord bx,
		input coord by);
		logic [11:0] endX;
		logic [11:0] endY;
		endX = {1'b0, bx} + 12'(spriteSize);
		endY = {1'b0, by} + 12'(spriteSize);
		return (px >= bx) && ({1'b0, px} < endX) && (py >= by) && ({1'b0, py} < endY);
	endfunction

	assign inCharacter = boxHit(pixelX, pixelY, characterX, characterY);
	assign inCoin = boxHit(pixelX, pixelY, coinX, coinY);

	// overlap drawn black, otherwise box colour over white
	always_comb
	begin
		case ({inCharacter, inCoin})
			2'b11: pixelColour = colourBoth;
			2'b10: pixelColour = colourCharacter;
			2'b01: pixelColour = colourCoin;
			default: pixelColour = colourBackground;
		endcase
	end

	// sticky until the CPU takes the bus back
	always_ff @(posedge clk)
	begin
		if (rst || !engineOwns)
			collision <= 1'b0;
		else if (pixelActive && inCharacter && inCoin)
			collision <= 1'b1;
	end

	assign finish = collision;

endmodule

`default_nettype wire

/* verilog/lt24Overlay.sv */
`timescale 1ns/1ps
`default_nettype none

module lt24Overlay #(
	parameter int unsigned stepPeriod = 1000000
) (
	input  logic clk,
	input  logic rst,
	// CPU side of the LT24 bus
	input  overlayPkg::pixelData cpuData,
	input  logic cpuWrN,
	input  logic cpuRdN,
	input  logic cpuCsN,
	input  logic cpuResetN,
	input  logic cpuRs,
	// panel side
	output overlayPkg::pixelData lcdData,
	output logic lcdWrN,
	output logic lcdRdN,
	output logic lcdCsN,
	output logic lcdResetN,
	output logic lcdRs,
	// game controls
	input  logic gameEnable,
	input  overlayPkg::velocity characterVelX,
	input  overlayPkg::velocity characterVelY,
	input  overlayPkg::coord coinStartX,
	input  overlayPkg::coord coinStartY,
	input  overlayPkg::velocity coinVelX,
	input  overlayPkg::velocity coinVelY,
	// game status
	output overlayPkg::coord characterX,
	output overlayPkg::coord characterY,
	output logic finish
);

	import overlayPkg::*;

	logic engineOwns;
	// engine side of the panel bus
	pixelData engData;
	logic engWrN;
	logic engCsN;
	logic engRs;
	// current pixel and its colour
	coord pixelX;
	coord pixelY;
	logic pixelActive;
	pixelData pixelColour;
	coord coinX;
	coord coinY;

	busOwner busOwner_i (
		.clk(clk), .rst(rst),
		.cpuData(cpuData), .cpuWrN(cpuWrN), .cpuRdN(cpuRdN),
		.cpuCsN(cpuCsN), .cpuResetN(cpuResetN), .cpuRs(cpuRs),
		.gameEnable(gameEnable),
		.engData(engData), .engWrN(engWrN), .engCsN(engCsN), .engRs(engRs),
		.engineOwns(engineOwns),
		.lcdData(lcdData), .lcdWrN(lcdWrN), .lcdRdN(lcdRdN),
		.lcdCsN(lcdCsN), .lcdResetN(lcdResetN), .lcdRs(lcdRs)
	);

	frameWriter frameWriter_i (
		.clk(clk), .rst(rst),
		.engineOwns(engineOwns), .pixelColour(pixelColour),
		.engData(engData), .engWrN(engWrN), .engCsN(engCsN), .engRs(engRs),
		.pixelX(pixelX), .pixelY(pixelY), .pixelActive(pixelActive)
	);

	gameObjects #(.stepPeriod(stepPeriod)) gameObjects_i (
		.clk(clk), .rst(rst), .engineOwns(engineOwns),
		.characterVelX(characterVelX), .characterVelY(characterVelY),
		.coinStartX(coinStartX), .coinStartY(coinStartY),
		.coinVelX(coinVelX), .coinVelY(coinVelY),
		.characterX(characterX), .characterY(characterY),
		.coinX(coinX), .coinY(coinY)
	);

	pixelShader pixelShader_i (
		.clk(clk), .rst(rst), .engineOwns(engineOwns),
		.pixelX(pixelX), .pixelY(pixelY), .pixelActive(pixelActive),
		.characterX(characterX), .characterY(characterY),
		.coinX(coinX), .coinY(coinY),
		.pixelColour(pixelColour), .finish(finish)
	);

endmodule

`default_nettype wire

/* bench/lt24OverlayTb_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module lt24OverlayTb_assert (
	input logic clk,
	input logic rst,
	input logic engWrN,
	input logic engineOwns,
	input logic pixelActive,
	input overlayPkg::frameIndex wordIndex
);

	import overlayPkg::*;

	// each strobe lasts a single cycle
	strobeRelease: assert property (@(posedge clk) disable iff (rst) !engWrN |=> engWrN)
		else $error("engine write strobe held low for two cycles");

	// no idle cycle between words while the engine keeps the panel
	strobeResume: assert property (@(posedge clk) disable iff (rst)
		(engineOwns && engWrN) ##1 engineOwns |-> !engWrN)
		else $error("engine skipped a write strobe while it owns the panel");

	// pixel words only after the setup words
	pixelPhase: assert property (@(posedge clk) disable iff (rst)
		pixelActive == (wordIndex >= setupWords))
		else $error("pixel phase and word index disagree");

endmodule

bind frameWriter lt24OverlayTb_assert frameWriterAssert_i (
	.clk(clk),
	.rst(rst),
	.engWrN(engWrN),
	.engineOwns(engineOwns),
	.pixelActive(pixelActive),
	.wordIndex(wordIndex)
);

`default_nettype wire

/* bench/lt24OverlayTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lt24OverlayTb;

	import overlayPkg::*;

	// one line of the trace file
	typedef struct {
		int resetFirst;
		int charVelX;
		int charVelY;
		int coinX;
		int coinY;
		int coinVelX;
		int coinVelY;
		int frames;
		int checkPixels;
		int expFinish;
		int expX;
		int expY;
	} traceRecord;

	logic clk = 1'b0;
	logic rst;
	// CPU side
	pixelData cpuData;
	logic cpuWrN;
	logic cpuRdN;
	logic cpuCsN;
	logic cpuResetN;
	logic cpuRs;
	// panel side
	pixelData lcdData;
	logic lcdWrN;
	logic lcdRdN;
	logic lcdCsN;
	logic lcdResetN;
	logic lcdRs;
	// game controls and status
	logic gameEnable;
	velocity characterVelX;
	velocity characterVelY;
	coord coinStartX;
	coord coinStartY;
	velocity coinVelX;
	velocity coinVelY;
	coord characterX;
	coord characterY;
	logic finish;

	traceRecord records[$];
	int errors = 0;
	int checks = 0;
	int seed = 96;
	int cycle = 0;
	int watchdogCycles = 0;
	int wordsPerFrame = setupWords + screenWidth * screenHeight;

	lt24Overlay #(.stepPeriod(1000)) lt24Overlay_i (
		.clk(clk), .rst(rst),
		.cpuData(cpuData), .cpuWrN(cpuWrN), .cpuRdN(cpuRdN),
		.cpuCsN(cpuCsN), .cpuResetN(cpuResetN), .cpuRs(cpuRs),
		.lcdData(lcdData), .lcdWrN(lcdWrN), .lcdRdN(lcdRdN),
		.lcdCsN(lcdCsN), .lcdResetN(lcdResetN), .lcdRs(lcdRs),
		.gameEnable(gameEnable),
		.characterVelX(characterVelX), .characterVelY(characterVelY),
		.coinStartX(coinStartX), .coinStartY(coinStartY),
		.coinVelX(coinVelX), .coinVelY(coinVelY),
		.characterX(characterX), .characterY(characterY), .finish(finish)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	// cycle count, used to measure strobe spacing
	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, msg, actual,
				expected);
		end
	endtask

	// CPU bus at rest, nothing selected
	task automatic driveCpuIdle();
		cpuData = '0;
		cpuWrN = 1'b1;
		cpuRdN = 1'b1;
		cpuCsN = 1'b1;
		cpuResetN = 1'b1;
		cpuRs = 1'b1;
	endtask

	task automatic applyReset();
		@(posedge clk);
		#1;
		rst = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	// skips comment lines starting with #
	task automatic readTrace();
		int fd;
		int n;
		string line;
		traceRecord r;
		fd = $fopen("bench/overlay_trace.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the trace file bench/overlay_trace.txt");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d", r.resetFirst,
				r.charVelX, r.charVelY, r.coinX, r.coinY, r.coinVelX, r.coinVelY,
				r.frames, r.checkPixels, r.expFinish, r.expX, r.expY);
			if (n == 12)
				records.push_back(r);
			else
			begin
				errors++;
				$display("trace line has %0d fields instead of 12: %s", n, line);
			end
		end
		$fclose(fd);
	endtask

	// random CPU traffic, every panel output must mirror its CPU input
	task automatic checkPassThrough(input int count);
		repeat (count)
		begin
			@(posedge clk);
			#1;
			cpuData = pixelData'($random(seed));
			cpuWrN = 1'($random(seed));
			cpuRdN = 1'($random(seed));
			cpuCsN = 1'($random(seed));
			cpuResetN = 1'($random(seed));
			cpuRs = 1'($random(seed));
			@(negedge clk);
			compare(lcdData, cpuData, "lcdData follows cpuData");
			compare(lcdWrN, cpuWrN, "lcdWrN follows cpuWrN");
			compare(lcdRdN, cpuRdN, "lcdRdN follows cpuRdN");
			compare(lcdCsN, cpuCsN, "lcdCsN follows cpuCsN");
			compare(lcdResetN, cpuResetN, "lcdResetN follows cpuResetN");
			compare(lcdRs, cpuRs, "lcdRs follows cpuRs");
		end
		@(posedge clk);
		#1;
		driveCpuIdle();
	endtask

	// memory write command on the CPU bus, claims or releases the panel
	task automatic sendCommand(input logic enable);
		@(posedge clk);
		#1;
		cpuData = cmdWrite;
		cpuRs = 1'b0;
		cpuCsN = 1'b0;
		cpuWrN = 1'b0;
		gameEnable = enable;
		@(posedge clk);
		#1;
		driveCpuIdle();
	endtask

	// column command, two zero words, page command, two zero words, write command
	function automatic void setupWord(input int index, output logic [15:0] data,
		output logic rs);
		data = '0;
		rs = 1'b1;
		if (index == 0 || index == 3 || index == 6)
			rs = 1'b0;
		if (index == 0)
			data = cmdColumn;
		else if (index == 3)
			data = cmdPage;
		else if (index == 6)
			data = cmdWrite;
	endfunction

	// half-open 20 by 20 boxes on white, black where they overlap
	function automatic logic [15:0] boxColour(input int x, input int y, input int charX,
		input int charY, input int coinX, input int coinY);
		logic inChar;
		logic inCoin;
		inChar = x >= charX && x < charX + spriteSize && y >= charY && y < charY + spriteSize;
		inCoin = x >= coinX && x < coinX + spriteSize && y >= coinY && y < coinY + spriteSize;
		if (inChar && inCoin)
			return colourBoth;
		if (inChar)
			return colourCharacter;
		if (inCoin)
			return colourCoin;
		return colourBackground;
	endfunction

	// follows the engine strobe by strobe through the given number of frames
	task automatic checkFrames(input traceRecord r);
		int f;
		int word;
		int waited;
		int lastCycle;
		int x;
		int y;
		logic [15:0] expData;
		logic expRs;
		for (f = 0; f < r.frames; f++)
		begin
			for (word = 0; word < wordsPerFrame; word++)
			begin
				waited = 0;
				@(negedge clk);
				while (lcdWrN && waited < 4)
				begin
					waited++;
					@(negedge clk);
				end
				if (lcdWrN)
				begin
					errors++;
					$display("engine stopped writing at word %0d of frame %0d", word, f);
					return;
				end
				// strobes every second cycle, across frame boundaries too
				if (f > 0 || word > 0)
					compare(cycle - lastCycle, 2, "strobe spacing");
				lastCycle = cycle;
				compare(lcdCsN, 0, "chip select with write strobe");
				compare(lcdRdN, 1, "no read while engine owns");
				compare(lcdResetN, cpuResetN, "panel reset stays with CPU");
				if (word < setupWords)
				begin
					setupWord(word, expData, expRs);
					compare(lcdData, expData, $sformatf("setup word %0d", word));
					compare(lcdRs, expRs, $sformatf("setup word %0d RS", word));
				end
				else
				begin
					compare(lcdRs, 1, "pixel RS");
					if (r.checkPixels != 0)
					begin
						x = (word - setupWords) % screenWidth;
						y = (word - setupWords) / screenWidth;
						compare(lcdData, boxColour(x, y, r.expX, r.expY, r.coinX, r.coinY),
							$sformatf("pixel %0d,%0d", x, y));
					end
				end
			end
		end
	endtask

	task automatic runRecord(input traceRecord r, input int index);
		if (r.resetFirst != 0)
			applyReset();
		@(posedge clk);
		#1;
		characterVelX = velocity'(r.charVelX);
		characterVelY = velocity'(r.charVelY);
		coinStartX = coord'(r.coinX);
		coinStartY = coord'(r.coinY);
		coinVelX = velocity'(r.coinVelX);
		coinVelY = velocity'(r.coinVelY);
		sendCommand(1'b1);
		// CPU read and panel reset low, read must stay hidden and reset must pass
		cpuRdN = 1'b0;
		cpuResetN = 1'b0;
		checkFrames(r);
		@(negedge clk);
		compare(finish, r.expFinish, $sformatf("record %0d finish", index));
		compare(characterX, r.expX, $sformatf("record %0d characterX", index));
		compare(characterY, r.expY, $sformatf("record %0d characterY", index));
		// give the panel back, CPU traffic must pass again
		sendCommand(1'b0);
		checkPassThrough(32);
		compare(finish, 0, $sformatf("record %0d finish after release", index));
	endtask

	initial
	begin
		rst = 1'b1;
		driveCpuIdle();
		gameEnable = 1'b0;
		characterVelX = '0;
		characterVelY = '0;
		coinStartX = '0;
		coinStartY = '0;
		coinVelX = '0;
		coinVelY = '0;
		readTrace();
		// two cycles per word plus margin for reset, commands and CPU traffic
		watchdogCycles = 4000;
		foreach (records[i])
			watchdogCycles += records[i].frames * 2 * wordsPerFrame + 2000;
		applyReset();
		checkPassThrough(64);
		foreach (records[i])
			runRecord(records[i], i);
		if (records.size() == 0)
		begin
			errors++;
			$display("the trace file held no test records");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// ends a stuck run
	initial
	begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge clk);
		$display("run did not finish within %0d cycles", watchdogCycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/overlay_trace.txt */
# columns: reset charVelX charVelY coinStartX coinStartY coinVelX coinVelY frames
#          checkPixels expFinish expCharX expCharY
# reset 1 pulses rst before the record, otherwise positions carry over
#
# both boxes still and apart, every pixel checked
0 0 0 100 100 0 0 1 1 0 10 10
#
# character runs right and clamps at 220
0 7 0 100 100 0 0 1 0 0 220 10
#
# velocity past the left edge respawns at 10
0 -300 0 100 100 0 0 1 0 0 10 10
#
# character runs down and clamps at 300
1 0 9 100 100 0 0 1 0 0 10 300
#
# coin placed over the character, every pixel checked
1 0 0 15 15 0 0 1 1 1 10 10

/* lt24Overlay.f */
verilog/overlayPkg.sv
verilog/busOwner.sv
verilog/frameWriter.sv
verilog/gameObjects.sv
verilog/pixelShader.sv
verilog/lt24Overlay.sv
bench/lt24OverlayTb_assert.sv
bench/lt24OverlayTb.sv

/* Bender.yml */
package:
  name: lt24Overlay

sources:
  - files:
      - verilog/overlayPkg.sv
      - verilog/busOwner.sv
      - verilog/frameWriter.sv
      - verilog/gameObjects.sv
      - verilog/pixelShader.sv
      - verilog/lt24Overlay.sv
  - target: simulation
    files:
      - bench/lt24OverlayTb_assert.sv
      - bench/lt24OverlayTb.sv
